// ==== logic/ucpd_timing_pkg.sv ====
package ucpd_timing_pkg;

  // ------------------------------
  // interval counters
  // ------------------------------

  // width of every edge interval counter
  localparam int cnt_w = 11;

  // one interval count, in ucpd_clk cycles
  typedef logic [cnt_w-1:0] ui_cnt_t;

  // ------------------------------
  // preamble averaging
  // ------------------------------

  // one-UI estimates summed before lock
  localparam int avg_samples = 16;
  localparam int avg_cnt_w   = 4;

  // sum of 16 estimates, with headroom
  typedef logic [19:0] ui_sum_t;

  // threshold = sum * 3 >> 6
  // same as three quarters of the average
  localparam int thresh_num   = 3;
  localparam int thresh_shift = 6;

  // cc input synchronizer depth
  localparam int sync_stages = 2;

endpackage

// ==== logic/ucpd_phy_pkg.sv ====
package ucpd_phy_pkg;

  // ------------------------------
  // preamble training
  // ------------------------------

  // capture covers three intervals, A B C
  typedef enum logic [1:0] {
    train_idle    = 2'd0,
    train_capture = 2'd1,
    train_average = 2'd2,
    train_locked  = 2'd3
  } train_state_t;

  // ------------------------------
  // rxfilte field
  // ------------------------------

  // set means no glitch filter at all
  localparam int rxfilte_bypass_bit = 0;
  // set = 2-sample OR, clear = 3-sample OR
  localparam int rxfilte_short_bit  = 1;

  // glitch filter shift register length
  localparam int filt_depth = 3;

endpackage

// ==== logic/cc_rx_frontend.sv ====
module cc_rx_frontend (
  input  logic       ucpd_clk,
  input  logic       ic_rst_n,
  input  logic       cc_in,
  input  logic [1:0] rxfilte,
  input  logic       phy_rx_en,
  output logic       cc_level,
  output logic       cc_edge_q
);

  logic [ucpd_timing_pkg::sync_stages-1:0] sync_sr;
  logic [ucpd_phy_pkg::filt_depth-1:0]     filt_sr;
  logic                                    sync_out;
  logic                                    filt_short;
  logic                                    filt_long;
  logic                                    filt_nxt;
  logic                                    cc_edge;
  logic                                    cc_edge_vld;

  // ------------------------------
  // synchronizer
  // ------------------------------
  // cc_in is fully async to ucpd_clk
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      sync_sr <= '0;
    end else begin
      sync_sr <= {sync_sr[ucpd_timing_pkg::sync_stages-2:0], cc_in};
    end
  end

  assign sync_out = sync_sr[ucpd_timing_pkg::sync_stages-1];

  // ------------------------------
  // glitch filter
  // ------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      filt_sr <= '0;
    end else begin
      filt_sr <= {filt_sr[ucpd_phy_pkg::filt_depth-2:0], sync_out};
    end
  end

  // OR of recent samples swallows short lows
  // rising edges pass through undelayed
  assign filt_short = |filt_sr[1:0];
  assign filt_long  = |filt_sr;

  // bypass still takes the first tap, so latency is the same for rises
  assign filt_nxt = rxfilte[ucpd_phy_pkg::rxfilte_bypass_bit] ? filt_sr[0] :
                    rxfilte[ucpd_phy_pkg::rxfilte_short_bit]  ? filt_short :
                                                                 filt_long;

  // ------------------------------
  // edge detect
  // ------------------------------
  assign cc_edge = filt_nxt ^ cc_level;

  // level and gated edge line up on the same cycle
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      cc_level  <= 1'b0;
      cc_edge_q <= 1'b0;
    end else begin
      cc_level  <= filt_nxt;
      cc_edge_q <= cc_edge & cc_edge_vld;
    end
  end

  // first edge only arms the flag, later ones pass
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      cc_edge_vld <= 1'b0;
    end else if (!phy_rx_en) begin
      cc_edge_vld <= 1'b0;
    end else if (cc_edge) begin
      cc_edge_vld <= 1'b1;
    end
  end

endmodule

// ==== logic/ui_trainer.sv ====
module ui_trainer #(
  parameter int cnt_width = ucpd_timing_pkg::cnt_w
) (
  input  logic                 ucpd_clk,
  input  logic                 ic_rst_n,
  input  logic                 cc_level,
  input  logic                 cc_edge_q,
  input  logic                 rx_pre_en,
  input  logic                 receive_en,
  output logic [cnt_width-1:0] ui_threshold,
  output logic                 train_locked
);

  localparam int sum_w = $bits(ucpd_timing_pkg::ui_sum_t);

  ucpd_phy_pkg::train_state_t                     state;
  logic [cnt_width-1:0]                           hi_cnt;
  logic [cnt_width-1:0]                           lo_cnt;
  logic [cnt_width-1:0]                           run_len;
  logic [cnt_width-1:0]                           ui_a;
  logic [cnt_width-1:0]                           ui_b;
  logic [cnt_width-1:0]                           ui_c;
  logic [cnt_width+1:0]                           abc_sum;
  logic [cnt_width-1:0]                           ui_est;
  logic [1:0]                                     cap_idx;
  logic                                           cap_full;
  logic                                           triple_ok;
  logic                                           triple_slip;
  logic                                           training;
  logic [ucpd_timing_pkg::avg_cnt_w-1:0]          avg_cnt;
  logic                                           avg_done;
  ucpd_timing_pkg::ui_sum_t                       ui_sum;
  logic [sum_w+1:0]                               thr_prod;

  assign training = (state == ucpd_phy_pkg::train_capture) ||
                    (state == ucpd_phy_pkg::train_average);

  assign train_locked = (state == ucpd_phy_pkg::train_locked);

  // ------------------------------
  // run-length counters
  // ------------------------------
  // cc_level already holds the new level on an edge,
  // so the finished run is the opposite counter
  assign run_len = cc_level ? lo_cnt : hi_cnt;

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      hi_cnt <= '0;
      lo_cnt <= '0;
    end else if (cc_level) begin
      lo_cnt <= '0;
      // saturate on long idle
      if (hi_cnt != '1) begin
        hi_cnt <= hi_cnt + 1'b1;
      end
    end else begin
      hi_cnt <= '0;
      if (lo_cnt != '1) begin
        lo_cnt <= lo_cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // triple capture
  // ------------------------------
  // preamble 0101 gives full, half, half intervals
  // good: full first or full last; full in the middle is off by one
  assign triple_ok   = ((ui_c > ui_a) && (ui_c > ui_b)) ||
                       ((ui_a > ui_b) && (ui_a > ui_c));
  assign triple_slip = (ui_b > ui_a) && (ui_b > ui_c);

  assign abc_sum = ui_a + ui_b + ui_c;

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      cap_idx  <= 2'd0;
      cap_full <= 1'b0;
    end else if (!training) begin
      cap_idx  <= 2'd0;
      cap_full <= 1'b0;
    end else begin
      cap_full <= 1'b0;
      if (cap_full && triple_slip) begin
        // restart one interval later, C becomes the new A
        cap_idx <= 2'd1;
      end else if (cc_edge_q) begin
        cap_idx  <= (cap_idx == 2'd2) ? 2'd0 : cap_idx + 2'd1;
        cap_full <= (cap_idx == 2'd2);
      end
    end
  end

  always_ff @(posedge ucpd_clk) begin
    if (training && cap_full && triple_slip) begin
      ui_a <= ui_c;
    end else if (training && cc_edge_q) begin
      case (cap_idx)
        2'd0:    ui_a <= run_len;
        2'd1:    ui_b <= run_len;
        default: ui_c <= run_len;
      endcase
    end
    // two halves plus one full = 2 UI
    if (cap_full && triple_ok) begin
      ui_est <= abc_sum[cnt_width:1];
    end
  end

  // ------------------------------
  // training FSM and averaging
  // ------------------------------
  assign thr_prod = (sum_w+2)'(ui_sum) * (sum_w+2)'(ucpd_timing_pkg::thresh_num);

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      state        <= ucpd_phy_pkg::train_idle;
      avg_cnt      <= '0;
      avg_done     <= 1'b0;
      ui_sum       <= '0;
      ui_threshold <= '0;
    end else begin
      case (state)
        ucpd_phy_pkg::train_idle: begin
          if (rx_pre_en) begin
            state <= ucpd_phy_pkg::train_capture;
          end
        end
        ucpd_phy_pkg::train_capture: begin
          if (!rx_pre_en) begin
            state <= ucpd_phy_pkg::train_idle;
          end else if (cap_full && triple_ok) begin
            state    <= ucpd_phy_pkg::train_average;
            avg_cnt  <= '0;
            avg_done <= 1'b0;
            ui_sum   <= '0;
          end
        end
        ucpd_phy_pkg::train_average: begin
          if (!rx_pre_en) begin
            state <= ucpd_phy_pkg::train_idle;
          end else if (avg_done) begin
            // full sum settled last cycle
            ui_threshold <= cnt_width'(thr_prod >> ucpd_timing_pkg::thresh_shift);
            state        <= ucpd_phy_pkg::train_locked;
          end else if (cc_edge_q) begin
            // estimate keeps refreshing from later triples
            ui_sum  <= ui_sum + ucpd_timing_pkg::ui_sum_t'(ui_est);
            avg_cnt <= avg_cnt + 1'b1;
            if (avg_cnt == ucpd_timing_pkg::avg_cnt_w'(ucpd_timing_pkg::avg_samples - 1)) begin
              avg_done <= 1'b1;
            end
          end
        end
        default: begin
          // hold threshold through the packet
          if (!rx_pre_en && !receive_en) begin
            state        <= ucpd_phy_pkg::train_idle;
            ui_threshold <= '0;
          end
        end
      endcase
    end
  end

endmodule

// ==== logic/bmc_bit_decoder.sv ====
module bmc_bit_decoder #(
  parameter int cnt_width = ucpd_timing_pkg::cnt_w
) (
  input  logic                 ucpd_clk,
  input  logic                 ic_rst_n,
  input  logic                 cc_edge_q,
  input  logic [cnt_width-1:0] ui_threshold,
  input  logic                 train_locked,
  input  logic                 phy_rx_en,
  input  logic                 eop_ok,
  input  logic                 hrst_vld,
  input  logic                 crst_vld,
  input  logic                 rx_idle_en,
  output logic                 decode_bmc,
  output logic                 receive_en
);

  logic [cnt_width-1:0] data_cnt;
  logic                 one_flag;
  logic                 short_int;
  logic                 rx_stop;
  logic                 locked_d;

  assign rx_stop   = eop_ok | rx_idle_en;
  // below 3/4 UI means a half-bit
  assign short_int = data_cnt < ui_threshold;

  // ------------------------------
  // interval counter
  // ------------------------------
  // counts from 1 so the value on an edge is the interval length
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      data_cnt <= '0;
      one_flag <= 1'b0;
    end else if (rx_stop || !receive_en) begin
      data_cnt <= '0;
      one_flag <= 1'b0;
    end else if (cc_edge_q) begin
      data_cnt <= cnt_width'(1);
      // halves pair up, a long run resyncs the pairing
      if (short_int) begin
        one_flag <= ~one_flag;
      end else begin
        one_flag <= 1'b0;
      end
    end else if (data_cnt != '1) begin
      data_cnt <= data_cnt + 1'b1;
    end
  end

  // ------------------------------
  // bit decision
  // ------------------------------
  // first short half leaves the output alone
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      decode_bmc <= 1'b0;
    end else if (rx_stop) begin
      decode_bmc <= 1'b0;
    end else if (receive_en && cc_edge_q) begin
      if (!short_int) begin
        decode_bmc <= 1'b0;
      end else if (one_flag) begin
        decode_bmc <= 1'b1;
      end
    end
  end

  // ------------------------------
  // receive enable
  // ------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      locked_d <= 1'b0;
    end else begin
      locked_d <= train_locked;
    end
  end

  // set on lock rise only, so a stop is not undone while lock lingers
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      receive_en <= 1'b0;
    end else if (eop_ok || hrst_vld || crst_vld || rx_idle_en) begin
      receive_en <= 1'b0;
    end else if (train_locked && !locked_d && phy_rx_en) begin
      receive_en <= 1'b1;
    end
  end

endmodule

// ==== logic/bmc_encoder.sv ====
module bmc_encoder (
  input  logic ucpd_clk,
  input  logic ic_rst_n,
  input  logic bmc_en,
  input  logic tx_bit,
  input  logic bit_clk_red,
  input  logic hbit_clk_red,
  output logic cc_out
);

  logic toggle;

  // ------------------------------
  // BMC transmit
  // ------------------------------
  // a zero flips only at bit start,
  // a one also flips mid-bit, and the half strobe covers both
  assign toggle = tx_bit ? hbit_clk_red : bit_clk_red;

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      cc_out <= 1'b0;
    end else if (!bmc_en) begin
      // line parks low between messages
      cc_out <= 1'b0;
    end else if (toggle) begin
      cc_out <= ~cc_out;
    end
  end

endmodule

// ==== logic/ucpd_bmc_phy.sv ====
module ucpd_bmc_phy #(
  parameter int cnt_width = ucpd_timing_pkg::cnt_w
) (
  input  logic       ucpd_clk,
  input  logic       ic_rst_n,
  input  logic       cc_in,
  input  logic [1:0] rxfilte,
  input  logic       phy_rx_en,
  input  logic       rx_pre_en,
  input  logic       eop_ok,
  input  logic       hrst_vld,
  input  logic       crst_vld,
  input  logic       rx_idle_en,
  input  logic       bmc_en,
  input  logic       tx_bit,
  input  logic       bit_clk_red,
  input  logic       hbit_clk_red,
  output logic       cc_out,
  output logic       decode_bmc,
  output logic       receive_en
);

  logic                 cc_level;
  logic                 cc_edge_q;
  logic [cnt_width-1:0] ui_threshold;
  logic                 train_locked;

  // ------------------------------
  // receive chain
  // ------------------------------
  cc_rx_frontend u_cc_rx_frontend (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .cc_in     (cc_in),
    .rxfilte   (rxfilte),
    .phy_rx_en (phy_rx_en),
    .cc_level  (cc_level),
    .cc_edge_q (cc_edge_q)
  );

  // UI measured over the preamble
  ui_trainer #(
    .cnt_width (cnt_width)
  ) u_ui_trainer (
    .ucpd_clk     (ucpd_clk),
    .ic_rst_n     (ic_rst_n),
    .cc_level     (cc_level),
    .cc_edge_q    (cc_edge_q),
    .rx_pre_en    (rx_pre_en),
    .receive_en   (receive_en),
    .ui_threshold (ui_threshold),
    .train_locked (train_locked)
  );

  bmc_bit_decoder #(
    .cnt_width (cnt_width)
  ) u_bmc_bit_decoder (
    .ucpd_clk     (ucpd_clk),
    .ic_rst_n     (ic_rst_n),
    .cc_edge_q    (cc_edge_q),
    .ui_threshold (ui_threshold),
    .train_locked (train_locked),
    .phy_rx_en    (phy_rx_en),
    .eop_ok       (eop_ok),
    .hrst_vld     (hrst_vld),
    .crst_vld     (crst_vld),
    .rx_idle_en   (rx_idle_en),
    .decode_bmc   (decode_bmc),
    .receive_en   (receive_en)
  );

  // ------------------------------
  // transmit
  // ------------------------------
  bmc_encoder u_bmc_encoder (
    .ucpd_clk     (ucpd_clk),
    .ic_rst_n     (ic_rst_n),
    .bmc_en       (bmc_en),
    .tx_bit       (tx_bit),
    .bit_clk_red  (bit_clk_red),
    .hbit_clk_red (hbit_clk_red),
    .cc_out       (cc_out)
  );

endmodule

// ==== include/tb_bmc_ref.svh ====
`ifndef tb_bmc_ref_svh
`define tb_bmc_ref_svh

// ------------------------------
// message timing in clocks
// ------------------------------
localparam int ui_clks    = 40;
localparam int half_clks  = 20;
localparam int pre_bits   = 64;
localparam int pay_bits   = 48;
localparam int idle_clks  = 20;
// decode sample point inside the next bit
localparam int sample_ofs = 30;

logic [15:0] lfsr_state = 16'd47434;
logic        line_lvl;
// one cc level per clock
logic        wave_q[$];
// every bit on the line, preamble included
logic        bit_q[$];

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic take_lfsr_bit();
  lfsr_state = lfsr_next(lfsr_state);
  return lfsr_state[0];
endfunction

// BMC: flip at bit start, flip again mid-bit for a one
function automatic void push_bmc_bit(input logic b);
  line_lvl = ~line_lvl;
  for (int i = 0; i < half_clks; i++) begin
    wave_q.push_back(line_lvl);
  end
  if (b) begin
    line_lvl = ~line_lvl;
  end
  for (int i = 0; i < half_clks; i++) begin
    wave_q.push_back(line_lvl);
  end
  bit_q.push_back(b);
endfunction

function automatic void build_message();
  wave_q.delete();
  bit_q.delete();
  line_lvl = 1'b0;
  for (int i = 0; i < idle_clks; i++) begin
    wave_q.push_back(1'b0);
  end
  // preamble 0101...
  for (int k = 0; k < pre_bits; k++) begin
    push_bmc_bit((k % 2) == 1);
  end
  for (int k = 0; k < pay_bits; k++) begin
    push_bmc_bit(take_lfsr_bit());
  end
  // trailing zero closes the last payload bit
  push_bmc_bit(1'b0);
  for (int i = 0; i < idle_clks; i++) begin
    wave_q.push_back(line_lvl);
  end
endfunction

// low glitches in the middle of each high half-bit
function automatic void inject_glitches(input int glen);
  int pos;
  for (int k = 0; k < bit_q.size(); k++) begin
    for (int h = 0; h < 2; h++) begin
      pos = idle_clks + k * ui_clks + half_clks / 2 + h * half_clks;
      if (glen > 0 && wave_q[pos] == 1'b1) begin
        for (int j = 0; j < glen; j++) begin
          wave_q[pos + j] = 1'b0;
        end
      end
    end
  end
endfunction

// bit k shows on the decoder during bit k+1
function automatic logic ref_decoded_bit(input int k);
  return bit_q[k];
endfunction

// line starts low, so the level is the toggle parity
function automatic logic ref_enc_level(input int toggles);
  return (toggles % 2) == 1;
endfunction

`endif

// ==== testbench/tb_ucpd_bmc_phy.sv ====
module tb_ucpd_bmc_phy;

  logic       ucpd_clk;
  logic       ic_rst_n;
  logic       cc_in;
  logic [1:0] rxfilte;
  logic       phy_rx_en;
  logic       rx_pre_en;
  logic       eop_ok;
  logic       hrst_vld;
  logic       crst_vld;
  logic       rx_idle_en;
  logic       bmc_en;
  logic       tx_bit;
  logic       bit_clk_red;
  logic       hbit_clk_red;
  logic       cc_out;
  logic       decode_bmc;
  logic       receive_en;

  // check requests for the compare process, one cycle each
  logic chk_idle;
  logic chk_enc;
  logic chk_dec;
  logic chk_rxen;
  logic chk_dec_low;
  logic exp_enc;
  logic exp_dec;
  logic exp_rxen;
  int   pre_end;

  `include "tb_bmc_ref.svh"

  ucpd_bmc_phy #(
    .cnt_width (ucpd_timing_pkg::cnt_w)
  ) DUT (
    .ucpd_clk     (ucpd_clk),
    .ic_rst_n     (ic_rst_n),
    .cc_in        (cc_in),
    .rxfilte      (rxfilte),
    .phy_rx_en    (phy_rx_en),
    .rx_pre_en    (rx_pre_en),
    .eop_ok       (eop_ok),
    .hrst_vld     (hrst_vld),
    .crst_vld     (crst_vld),
    .rx_idle_en   (rx_idle_en),
    .bmc_en       (bmc_en),
    .tx_bit       (tx_bit),
    .bit_clk_red  (bit_clk_red),
    .hbit_clk_red (hbit_clk_red),
    .cc_out       (cc_out),
    .decode_bmc   (decode_bmc),
    .receive_en   (receive_en)
  );

  always #50 ucpd_clk = ~ucpd_clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  // ------------------------------
  // compare process
  // ------------------------------
  // mid-cycle, well clear of the drive point
  always @(negedge ucpd_clk) begin
    if (chk_idle) begin
      assert (cc_out === 1'b0 && decode_bmc === 1'b0 && receive_en === 1'b0)
        else report_failure($sformatf("mismatch at %0t: outputs not low after reset", $time));
    end
    if (chk_enc) begin
      assert (cc_out === exp_enc)
        else report_failure($sformatf("mismatch at %0t: cc_out %b, expected %b",
                                      $time, cc_out, exp_enc));
    end
    if (chk_dec) begin
      assert (decode_bmc === exp_dec)
        else report_failure($sformatf("mismatch at %0t: decode_bmc %b, expected %b",
                                      $time, decode_bmc, exp_dec));
    end
    if (chk_rxen) begin
      assert (receive_en === exp_rxen)
        else report_failure($sformatf("mismatch at %0t: receive_en %b, expected %b",
                                      $time, receive_en, exp_rxen));
    end
    if (chk_dec_low) begin
      assert (decode_bmc === 1'b0)
        else report_failure($sformatf("mismatch at %0t: decode_bmc not cleared", $time));
    end
  end

  // ------------------------------
  // drive helpers
  // ------------------------------
  // inputs change 10 units after the rising edge
  task automatic step_clk();
    @(posedge ucpd_clk);
    #10;
    chk_idle    = 1'b0;
    chk_enc     = 1'b0;
    chk_dec     = 1'b0;
    chk_rxen    = 1'b0;
    chk_dec_low = 1'b0;
  endtask

  task automatic reset_dut();
    ic_rst_n     = 1'b0;
    cc_in        = 1'b0;
    rxfilte      = 2'b01;
    phy_rx_en    = 1'b0;
    rx_pre_en    = 1'b0;
    eop_ok       = 1'b0;
    hrst_vld     = 1'b0;
    crst_vld     = 1'b0;
    rx_idle_en   = 1'b0;
    bmc_en       = 1'b0;
    tx_bit       = 1'b0;
    bit_clk_red  = 1'b0;
    hbit_clk_red = 1'b0;
    repeat (10) step_clk();
    ic_rst_n = 1'b1;
  endtask

  task automatic drive_wave_cycle(input int i);
    step_clk();
    cc_in      = wave_q[i];
    rx_pre_en  = (i < pre_end);
    eop_ok     = 1'b0;
    hrst_vld   = 1'b0;
    crst_vld   = 1'b0;
    rx_idle_en = 1'b0;
  endtask

  // ------------------------------
  // encoder run
  // ------------------------------
  task automatic run_encoder();
    int   toggles;
    logic tx;
    toggles = 0;
    // strobes while disabled must not move the line
    for (int c = 0; c < 40; c++) begin
      step_clk();
      tx_bit       = 1'b1;
      bit_clk_red  = (c % 40) == 0;
      hbit_clk_red = (c % 20) == 0;
      chk_enc      = 1'b1;
      exp_enc      = 1'b0;
    end
    step_clk();
    bmc_en = 1'b1;
    for (int b = 0; b < 200; b++) begin
      tx = take_lfsr_bit();
      for (int c = 0; c < ui_clks; c++) begin
        step_clk();
        tx_bit       = tx;
        bit_clk_red  = (c == 0);
        hbit_clk_red = (c == 0) || (c == half_clks);
        if (c == 1 || c == half_clks + 1) begin
          chk_enc = 1'b1;
          exp_enc = ref_enc_level(toggles);
        end
        if (c == 0 || (c == half_clks && tx)) begin
          toggles++;
        end
      end
    end
    step_clk();
    bmc_en = 1'b0;
    for (int c = 0; c < 40; c++) begin
      step_clk();
      bit_clk_red  = (c % 40) == 0;
      hbit_clk_red = (c % 20) == 0;
      chk_enc      = 1'b1;
      exp_enc      = 1'b0;
    end
  endtask

  // ------------------------------
  // receive run
  // ------------------------------
  // stop_sel: 0 none, 1 eop_ok, 2 hrst_vld, 3 crst_vld, 4 rx_idle_en
  task automatic run_rx(input logic [1:0] filt, input int glen, input int stop_sel);
    int   i;
    int   rel;
    int   kk;
    int   stop_k;
    int   stop_at;
    int   wait_cnt;
    logic stopped;
    reset_dut();
    build_message();
    inject_glitches(glen);
    pre_end = idle_clks + pre_bits * ui_clks;
    // stop on a decoded one so the clear is visible
    stop_k = pre_bits + 4;
    while (stop_k < pre_bits + pay_bits - 2 && bit_q[stop_k] != 1'b1) begin
      stop_k++;
    end
    stop_at   = (stop_sel == 0) ? -1 : idle_clks + (stop_k + 1) * ui_clks + sample_ofs;
    rxfilte   = filt;
    phy_rx_en = 1'b1;
    stopped   = 1'b0;
    i = 0;
    while (i < wave_q.size()) begin
      drive_wave_cycle(i);
      rel = i - idle_clks;
      // lock must come inside the preamble
      if (i == pre_end - 1) begin
        chk_rxen = 1'b1;
        exp_rxen = 1'b1;
      end
      if (!stopped && rel >= ui_clks && (rel % ui_clks) == sample_ofs) begin
        kk = rel / ui_clks - 1;
        if (kk >= pre_bits && kk < pre_bits + pay_bits) begin
          chk_dec = 1'b1;
          exp_dec = ref_decoded_bit(kk);
        end
      end
      if (stopped) begin
        chk_rxen    = 1'b1;
        exp_rxen    = 1'b0;
        chk_dec_low = (stop_sel == 1) || (stop_sel == 4);
      end
      if (i == stop_at) begin
        case (stop_sel)
          1:       eop_ok     = 1'b1;
          2:       hrst_vld   = 1'b1;
          3:       crst_vld   = 1'b1;
          default: rx_idle_en = 1'b1;
        endcase
        stopped  = 1'b1;
        wait_cnt = 0;
        while (receive_en !== 1'b0) begin
          if (wait_cnt == 2) begin
            report_failure("receive_en did not fall within 2 cycles of the stop pulse");
          end else begin
            i++;
            drive_wave_cycle(i);
            wait_cnt++;
          end
        end
      end
      i++;
    end
  endtask

  initial begin
    ucpd_clk    = 1'b0;
    chk_idle    = 1'b0;
    chk_enc     = 1'b0;
    chk_dec     = 1'b0;
    chk_rxen    = 1'b0;
    chk_dec_low = 1'b0;
    exp_enc     = 1'b0;
    exp_dec     = 1'b0;
    exp_rxen    = 1'b0;
    pre_end     = 0;
    reset_dut();
    repeat (20) begin
      step_clk();
      chk_idle = 1'b1;
    end
    run_encoder();
    // bypass, then 2-sample and 3-sample filters with glitches
    run_rx(2'b01, 0, 0);
    run_rx(2'b10, 1, 0);
    run_rx(2'b00, 2, 0);
    for (int s = 1; s <= 4; s++) begin
      run_rx(2'b01, 0, s);
    end
    step_clk();
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== ucpd_bmc.f ====
+incdir+include
logic/ucpd_timing_pkg.sv
logic/ucpd_phy_pkg.sv
logic/cc_rx_frontend.sv
logic/ui_trainer.sv
logic/bmc_bit_decoder.sv
logic/bmc_encoder.sv
logic/ucpd_bmc_phy.sv
testbench/tb_ucpd_bmc_phy.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the ucpd_bmc testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ucpd_bmc_phy \
  -f ucpd_bmc.f \
  -o tb_ucpd_bmc_phy
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_ucpd_bmc_phy
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
